//--- mini_core_accel_defs.svh
// Multiply accelerator definitions
`ifndef MINI_CORE_ACCEL_DEFS_SVH
`define MINI_CORE_ACCEL_DEFS_SVH

// ---------------------------------------------------------------------
// Datapath width
// ---------------------------------------------------------------------

// Signed operand width, product is twice as wide
`define NUM_WIDTH 8

// ---------------------------------------------------------------------
// Register map, byte offsets of 32-bit words
// ---------------------------------------------------------------------

// Multiplicand in 7:0, multiplier in 15:8
`define REG_OPERANDS 4'h0
// Start and interrupt enable
`define REG_CTRL     4'h4
// Busy and sticky done
`define REG_STATUS   4'h8
// Signed product, sign extended on read
`define REG_RESULT   4'hC

// ---------------------------------------------------------------------
// Control and status bit positions
// ---------------------------------------------------------------------

// Writing 1 launches a multiply, always reads back 0
`define CTRL_START_BIT  0
`define CTRL_IRQEN_BIT  1

`define STATUS_BUSY_BIT 0
`define STATUS_DONE_BIT 1

`endif

//--- mini_core_accel_pkg.sv
// Multiply accelerator types
`include "mini_core_accel_defs.svh"

package mini_core_accel_pkg;

    // ---------------------------------------------------------------------
    // Booth core FSM
    // ---------------------------------------------------------------------

    // Core waits in IDLE, then alternates the two working states
    // once per multiplier bit
    typedef enum logic [1:0] {
        IDLE                   = 2'd0,
        SUB_OR_ADD_AM          = 2'd1,
        ARITHMETIC_SHIFT_RIGHT = 2'd2
    } t_boothState;

    // ---------------------------------------------------------------------
    // Register word index
    // ---------------------------------------------------------------------

    // Word index is the byte offset without the two low bits
    typedef enum logic [1:0] {
        ACCEL_OPERANDS = 2'((`REG_OPERANDS) >> 2),
        ACCEL_CTRL     = 2'((`REG_CTRL) >> 2),
        ACCEL_STATUS   = 2'((`REG_STATUS) >> 2),
        ACCEL_RESULT   = 2'((`REG_RESULT) >> 2)
    } t_accelReg;

endpackage

//--- booth_multiplier.sv
// Booth multiplier core
`timescale 1ns/1ps
`include "mini_core_accel_defs.svh"

module booth_multiplier
    import mini_core_accel_pkg::*;
(
    input  logic                       Clock,
    input  logic                       Reset,
    input  logic                       ReqValid,
    input  logic [`NUM_WIDTH-1:0]      Multiplicand,
    input  logic [`NUM_WIDTH-1:0]      Multiplier,
    output logic                       Busy,
    output logic                       RspValid,
    output logic [2*`NUM_WIDTH-1:0]    Result
);

    // Counter has to hold NUM_WIDTH itself
    localparam int CntWidth = $clog2(`NUM_WIDTH) + 1;

    t_boothState                State;
    t_boothState                NextState;
    // Accumulator with a guard bit, multiplier and the extra Booth bit in one register
    logic [2*`NUM_WIDTH+1:0]    AccMultLsb;
    logic [2*`NUM_WIDTH+1:0]    NextAccMultLsb;
    logic [2*`NUM_WIDTH+1:0]    ShiftedAcc;
    logic [`NUM_WIDTH-1:0]      StoredMcand;
    logic [`NUM_WIDTH-1:0]      NextStoredMcand;
    // Multiplicand widened to the accumulator, so -128 can be negated
    logic [`NUM_WIDTH:0]        ExtMcand;
    logic [CntWidth-1:0]        ItrNum;
    logic [CntWidth-1:0]        NextItrNum;

    // ---------------------------------------------------------------------
    // State registers
    // ---------------------------------------------------------------------

    always_ff @(posedge Clock) begin
        if (Reset) begin
            State  <= IDLE;
            ItrNum <= '0;
        end else begin
            State  <= NextState;
            ItrNum <= NextItrNum;
        end
    end

    // Datapath, only meaningful while a multiply runs
    always_ff @(posedge Clock) begin
        AccMultLsb  <= NextAccMultLsb;
        StoredMcand <= NextStoredMcand;
    end

    assign ExtMcand = {StoredMcand[`NUM_WIDTH-1], StoredMcand};

    // Arithmetic shift of the full register, sign taken from the top bit
    assign ShiftedAcc = $signed(AccMultLsb) >>> 1;

    // ---------------------------------------------------------------------
    // Response
    // ---------------------------------------------------------------------

    assign Busy     = (State != IDLE);
    // Last shift of the last iteration
    assign RspValid = (State == ARITHMETIC_SHIFT_RIGHT) && (ItrNum == '0);
    // Product without the guard bit and the extra Booth bit
    assign Result   = ShiftedAcc[2*`NUM_WIDTH:1];

    // ---------------------------------------------------------------------
    // Next state logic
    // ---------------------------------------------------------------------

    always_comb begin
        NextState       = State;
        NextItrNum      = ItrNum;
        NextAccMultLsb  = AccMultLsb;
        NextStoredMcand = StoredMcand;

        case (State)
            IDLE: begin
                if (ReqValid) begin
                    NextState       = SUB_OR_ADD_AM;
                    NextStoredMcand = Multiplicand;
                    NextAccMultLsb  = {{(`NUM_WIDTH+1){1'b0}}, Multiplier, 1'b0};
                    NextItrNum      = CntWidth'(`NUM_WIDTH);
                end
            end

            SUB_OR_ADD_AM: begin
                // 01 ends a run of ones, 10 starts one
                case (AccMultLsb[1:0])
                    2'b01: begin
                        NextAccMultLsb[2*`NUM_WIDTH+1:`NUM_WIDTH+1] =
                            AccMultLsb[2*`NUM_WIDTH+1:`NUM_WIDTH+1] + ExtMcand;
                    end
                    2'b10: begin
                        NextAccMultLsb[2*`NUM_WIDTH+1:`NUM_WIDTH+1] =
                            AccMultLsb[2*`NUM_WIDTH+1:`NUM_WIDTH+1] - ExtMcand;
                    end
                    default: begin
                        NextAccMultLsb = AccMultLsb;
                    end
                endcase
                NextItrNum = ItrNum - 1'b1;
                NextState  = ARITHMETIC_SHIFT_RIGHT;
            end

            ARITHMETIC_SHIFT_RIGHT: begin
                NextAccMultLsb = ShiftedAcc;
                if (ItrNum != '0) begin
                    NextState = SUB_OR_ADD_AM;
                end else begin
                    NextState = IDLE;
                end
            end

            default: begin
                NextState = IDLE;
            end
        endcase
    end

endmodule

//--- mul_apb_regs.sv
// APB register block for the multiplier
`timescale 1ns/1ps
`include "mini_core_accel_defs.svh"

module mul_apb_regs
    import mini_core_accel_pkg::*;
(
    input  logic                       Clock,
    input  logic                       Reset,

    // APB slave
    input  logic                       Psel,
    input  logic                       Penable,
    input  logic                       Pwrite,
    input  logic [3:0]                 Paddr,
    input  logic [31:0]                Pwdata,
    output logic [31:0]                Prdata,
    output logic                       Pready,
    output logic                       Pslverr,
    output logic                       Irq,

    // Booth core request side
    output logic                       ReqValid,
    output logic [`NUM_WIDTH-1:0]      Multiplicand,
    output logic [`NUM_WIDTH-1:0]      Multiplier,

    // Booth core response side
    input  logic                       Busy,
    input  logic                       RspValid,
    input  logic [2*`NUM_WIDTH-1:0]    Result
);

    localparam int ExtWidth = 32 - 2*`NUM_WIDTH;

    t_accelReg                  RegIdx;
    logic                       Access;
    logic                       WriteAccess;
    logic                       ReadAccess;
    logic                       AddrValid;
    logic                       StartReq;
    logic                       CoreActive;
    logic                       WriteOk;
    logic                       StartOk;
    logic                       ResultRead;

    logic                       IrqEn;
    logic                       Done;
    logic [2*`NUM_WIDTH-1:0]    ResultReg;

    logic [31:0]                OperandWord;
    logic [31:0]                CtrlWord;
    logic [31:0]                StatusWord;
    logic [31:0]                ResultWord;

    // ---------------------------------------------------------------------
    // Transfer decode
    // ---------------------------------------------------------------------

    // No wait states
    assign Pready = 1'b1;

    assign Access      = Psel && Penable;
    assign WriteAccess = Access && Pwrite;
    assign ReadAccess  = Access && !Pwrite;

    // Only word aligned offsets hit a register
    assign RegIdx    = t_accelReg'(Paddr[3:2]);
    assign AddrValid = (Paddr[1:0] == 2'b00);

    assign StartReq = WriteAccess && AddrValid && (RegIdx == ACCEL_CTRL) &&
                      Pwdata[`CTRL_START_BIT];

    // Request pulse still in flight counts as busy too
    assign CoreActive = Busy || ReqValid;

    assign Pslverr = Access && (!AddrValid || (StartReq && CoreActive));

    // Rejected writes leave every register untouched
    assign WriteOk    = WriteAccess && !Pslverr;
    assign StartOk    = StartReq && !CoreActive;
    assign ResultRead = ReadAccess && AddrValid && (RegIdx == ACCEL_RESULT);

    // ---------------------------------------------------------------------
    // Operand and control registers
    // ---------------------------------------------------------------------

    always_ff @(posedge Clock) begin
        if (Reset) begin
            Multiplicand <= '0;
            Multiplier   <= '0;
            IrqEn        <= 1'b0;
            ReqValid     <= 1'b0;
        end else begin
            // One cycle pulse after an accepted start
            ReqValid <= StartOk;
            if (WriteOk && (RegIdx == ACCEL_OPERANDS)) begin
                Multiplicand <= Pwdata[`NUM_WIDTH-1:0];
                Multiplier   <= Pwdata[2*`NUM_WIDTH-1:`NUM_WIDTH];
            end
            if (WriteOk && (RegIdx == ACCEL_CTRL)) begin
                IrqEn <= Pwdata[`CTRL_IRQEN_BIT];
            end
        end
    end

    // ---------------------------------------------------------------------
    // Result capture and done flag
    // ---------------------------------------------------------------------

    always_ff @(posedge Clock) begin
        if (Reset) begin
            Done      <= 1'b0;
            ResultReg <= '0;
        end else begin
            if (RspValid) begin
                ResultReg <= Result;
                Done      <= 1'b1;
            end else if (StartOk || ResultRead) begin
                // Sticky until consumed or a new multiply begins
                Done <= 1'b0;
            end
        end
    end

    assign Irq = Done && IrqEn;

    // ---------------------------------------------------------------------
    // Read data
    // ---------------------------------------------------------------------

    always_comb begin
        OperandWord = '0;
        OperandWord[`NUM_WIDTH-1:0]           = Multiplicand;
        OperandWord[2*`NUM_WIDTH-1:`NUM_WIDTH] = Multiplier;

        // Start bit is write only
        CtrlWord = '0;
        CtrlWord[`CTRL_IRQEN_BIT] = IrqEn;

        StatusWord = '0;
        StatusWord[`STATUS_BUSY_BIT] = CoreActive;
        StatusWord[`STATUS_DONE_BIT] = Done;

        ResultWord = {{ExtWidth{ResultReg[2*`NUM_WIDTH-1]}}, ResultReg};
    end

    always_comb begin
        Prdata = '0;
        if (AddrValid) begin
            case (RegIdx)
                ACCEL_OPERANDS: Prdata = OperandWord;
                ACCEL_CTRL:     Prdata = CtrlWord;
                ACCEL_STATUS:   Prdata = StatusWord;
                ACCEL_RESULT:   Prdata = ResultWord;
                default:        Prdata = '0;
            endcase
        end
    end

endmodule

//--- mini_core_accel_top.sv
// Multiply accelerator top level
`timescale 1ns/1ps
`include "mini_core_accel_defs.svh"

module mini_core_accel_top (
    input  logic           Clock,
    input  logic           Reset,

    // APB3 slave port
    input  logic           Psel,
    input  logic           Penable,
    input  logic           Pwrite,
    input  logic [3:0]     Paddr,
    input  logic [31:0]    Pwdata,
    output logic [31:0]    Prdata,
    output logic           Pready,
    output logic           Pslverr,

    // Done interrupt
    output logic           Irq
);

    // ---------------------------------------------------------------------
    // Register block to core
    // ---------------------------------------------------------------------

    logic                       ReqValid;
    logic [`NUM_WIDTH-1:0]      Multiplicand;
    logic [`NUM_WIDTH-1:0]      Multiplier;
    logic                       Busy;
    logic                       RspValid;
    logic [2*`NUM_WIDTH-1:0]    Result;

    mul_apb_regs mul_apb_regs_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .Psel         (Psel),
        .Penable      (Penable),
        .Pwrite       (Pwrite),
        .Paddr        (Paddr),
        .Pwdata       (Pwdata),
        .Prdata       (Prdata),
        .Pready       (Pready),
        .Pslverr      (Pslverr),
        .Irq          (Irq),
        .ReqValid     (ReqValid),
        .Multiplicand (Multiplicand),
        .Multiplier   (Multiplier),
        .Busy         (Busy),
        .RspValid     (RspValid),
        .Result       (Result)
    );

    // Single multiply in flight
    booth_multiplier booth_multiplier_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .ReqValid     (ReqValid),
        .Multiplicand (Multiplicand),
        .Multiplier   (Multiplier),
        .Busy         (Busy),
        .RspValid     (RspValid),
        .Result       (Result)
    );

endmodule

//--- mini_core_accel_tb.sv
// Multiply accelerator testbench
`timescale 1ns/1ps
`include "mini_core_accel_defs.svh"

module mini_core_accel_tb
    import mini_core_accel_pkg::*;
();

    logic           Clock;
    logic           Reset;
    logic           Psel;
    logic           Penable;
    logic           Pwrite;
    logic [3:0]     Paddr;
    logic [31:0]    Pwdata;
    logic [31:0]    Prdata;
    logic           Pready;
    logic           Pslverr;
    logic           Irq;

    int             errorCount;
    int             timeoutCount;
    int             cycleCount;
    logic [31:0]    lfsrState;
    logic [31:0]    expQ[$];
    logic [31:0]    gotQ[$];

    mini_core_accel_top mini_core_accel_top_i (
        .Clock   (Clock),
        .Reset   (Reset),
        .Psel    (Psel),
        .Penable (Penable),
        .Pwrite  (Pwrite),
        .Paddr   (Paddr),
        .Pwdata  (Pwdata),
        .Prdata  (Prdata),
        .Pready  (Pready),
        .Pslverr (Pslverr),
        .Irq     (Irq)
    );

    always #4 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
    end

    // ---------------------------------------------------------------------
    // Reference model, stimulus and checking helpers
    // ---------------------------------------------------------------------

    // Signed 8x8 product, sign extended to a full bus word
    function automatic logic [31:0] boothRef(input logic [7:0] a, input logic [7:0] b);
        logic signed [15:0] product;
        product = $signed(a) * $signed(b);
        return {{16{product[15]}}, product};
    endfunction

    function automatic logic [3:0] regAddr(input t_accelReg r);
        return {r, 2'b00};
    endfunction

    // Taps 32, 22, 2, 1, one step per bit taken
    function automatic logic [7:0] nextRandomByte();
        logic       feedback;
        logic [7:0] value;
        for (int i = 0; i < 8; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value[i]  = feedback;
        end
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
            errorCount++;
        end
    endtask

    // Products are compared here as they come back from the bus
    always @(posedge Clock) begin
        if (gotQ.size() > 0 && expQ.size() > 0) begin
            checkValue("Result", gotQ.pop_front(), expQ.pop_front());
        end
    end

    // ---------------------------------------------------------------------
    // APB transfers
    // ---------------------------------------------------------------------

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data,
                            output logic slverr);
        @(posedge Clock);
        Psel    <= 1'b1;
        Penable <= 1'b0;
        Pwrite  <= 1'b1;
        Paddr   <= addr;
        Pwdata  <= data;
        @(posedge Clock);
        Penable <= 1'b1;
        @(negedge Clock);
        slverr = Pslverr;
        checkValue("Pready", Pready, 1);
        @(posedge Clock);
        Psel    <= 1'b0;
        Penable <= 1'b0;
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data,
                           output logic slverr);
        @(posedge Clock);
        Psel    <= 1'b1;
        Penable <= 1'b0;
        Pwrite  <= 1'b0;
        Paddr   <= addr;
        @(posedge Clock);
        Penable <= 1'b1;
        @(negedge Clock);
        data   = Prdata;
        slverr = Pslverr;
        checkValue("Pready", Pready, 1);
        @(posedge Clock);
        Psel    <= 1'b0;
        Penable <= 1'b0;
    endtask

    // Polls status until done, bounded by 100 cycles
    task automatic waitDone(output logic [31:0] status);
        int   startCycle;
        logic err;
        startCycle = cycleCount;
        status     = '0;
        while (!status[`STATUS_DONE_BIT] && (cycleCount - startCycle) < 100) begin
            apbRead(regAddr(ACCEL_STATUS), status, err);
        end
        if (!status[`STATUS_DONE_BIT]) begin
            $display("Timeout: done flag did not set within 100 cycles");
            timeoutCount++;
        end
    endtask

    // Full multiply through the register map
    task automatic runProduct(input logic [7:0] a, input logic [7:0] b, input logic irqEn);
        logic [31:0] data;
        logic        err;
        apbWrite(regAddr(ACCEL_OPERANDS), {16'h0, b, a}, err);
        checkValue("Pslverr", err, 0);
        apbWrite(regAddr(ACCEL_CTRL), (32'(irqEn) << `CTRL_IRQEN_BIT) | 32'h1, err);
        checkValue("Pslverr", err, 0);
        expQ.push_back(boothRef(a, b));
        apbRead(regAddr(ACCEL_STATUS), data, err);
        checkValue("StatusBusy", data[`STATUS_BUSY_BIT], 1);
        checkValue("StatusDone", data[`STATUS_DONE_BIT], 0);
        waitDone(data);
        checkValue("StatusBusy", data[`STATUS_BUSY_BIT], 0);
        @(negedge Clock);
        checkValue("Irq", Irq, irqEn);
        apbRead(regAddr(ACCEL_RESULT), data, err);
        gotQ.push_back(data);
        @(negedge Clock);
        checkValue("Irq", Irq, 0);
        apbRead(regAddr(ACCEL_STATUS), data, err);
        checkValue("StatusDone", data[`STATUS_DONE_BIT], 0);
    endtask

    // ---------------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------------

    initial begin
        logic [31:0] data;
        logic        err;
        logic [7:0]  a;
        logic [7:0]  b;
        int          waitCycles;

        Clock        = 1'b0;
        Reset        = 1'b1;
        Psel         = 1'b0;
        Penable      = 1'b0;
        Pwrite       = 1'b0;
        Paddr        = '0;
        Pwdata       = '0;
        errorCount   = 0;
        timeoutCount = 0;
        cycleCount   = 0;
        lfsrState    = 32'h12ee4735;
        repeat (4) @(posedge Clock);
        Reset <= 1'b0;

        // All registers read zero after reset
        for (int r = 0; r < 4; r++) begin
            apbRead(regAddr(t_accelReg'(r)), data, err);
            checkValue("Prdata", data, 0);
            checkValue("Pslverr", err, 0);
        end
        checkValue("Irq", Irq, 0);

        // Corner operands
        runProduct(8'h80, 8'h80, 1'b0);
        runProduct(8'h80, 8'h7f, 1'b0);
        runProduct(8'h7f, 8'h7f, 1'b0);
        runProduct(8'h00, 8'hff, 1'b0);
        runProduct(8'hff, 8'hff, 1'b0);

        for (int i = 0; i < 40; i++) begin
            a = nextRandomByte();
            b = nextRandomByte();
            runProduct(a, b, 1'b0);
        end

        // Second start while busy, operands overwritten meanwhile
        apbWrite(regAddr(ACCEL_OPERANDS), {16'h0, 8'h9c, 8'h35}, err);
        apbWrite(regAddr(ACCEL_CTRL), 32'h1, err);
        expQ.push_back(boothRef(8'h35, 8'h9c));
        apbWrite(regAddr(ACCEL_OPERANDS), {16'h0, 8'h11, 8'h22}, err);
        checkValue("Pslverr", err, 0);
        apbWrite(regAddr(ACCEL_CTRL), 32'h1, err);
        checkValue("Pslverr", err, 1);
        waitDone(data);
        apbRead(regAddr(ACCEL_RESULT), data, err);
        gotQ.push_back(data);

        // Unaligned offsets fall outside the map
        apbRead(4'h2, data, err);
        checkValue("Pslverr", err, 1);
        apbWrite(4'h5, 32'h1, err);
        checkValue("Pslverr", err, 1);

        // Interrupt enabled, then disabled again
        runProduct(8'hc3, 8'h5a, 1'b1);
        runProduct(8'h81, 8'h02, 1'b1);
        runProduct(8'h7e, 8'hf0, 1'b0);

        waitCycles = 0;
        while (gotQ.size() > 0 && waitCycles < 10) begin
            @(posedge Clock);
            waitCycles++;
        end
        if (gotQ.size() > 0) begin
            $display("Timeout: result compare queue did not drain");
            timeoutCount++;
        end

        $display("Errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- mini_core_accel_top.f
+incdir+.
mini_core_accel_pkg.sv
booth_multiplier.sv
mul_apb_regs.sv
mini_core_accel_top.sv
mini_core_accel_tb.sv
